// ==== div_consts.svh ====
// Widths are fixed here; DIV_CNT_WIDTH must hold the value DIV_WIDTH and the bus is word addressed.
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// Operand, quotient and remainder width.
`define DIV_WIDTH 16

// Iteration counter counts down from DIV_WIDTH to zero.
`define DIV_CNT_WIDTH 5

`define WB_DATA_WIDTH 32 // Wishbone data width.
`define WB_ADDR_WIDTH 3 // Wishbone word address width.

`endif

// ==== div_pkg.sv ====
// Register addresses 6 and 7 have no enum entry and are treated as unmapped.
`include "div_consts.svh"

package div_pkg;

  // Divider controller states.
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0, // Waiting for a request.
    ST_ITER = 2'd1, // One restoring step per cycle.
    ST_HOLD = 2'd2 // Result offered, consumer not ready.
  } div_state_e;

  typedef enum logic [`WB_ADDR_WIDTH-1:0] {
    REG_DIVIDEND = 3'd0,
    REG_DIVISOR = 3'd1,
    REG_CTRL = 3'd2, // Write only; bit 0 starts a division.
    REG_STATUS = 3'd3, // Read only; busy, done, pending.
    REG_QUOT = 3'd4, // Reading it clears done.
    REG_REM = 3'd5
  } div_reg_e;

endpackage

// ==== div_ctrl_if.sv ====
// Single-bit strobes only; step and latch_q are meaningful only in the iterate state.
`timescale 1ns/1ns

interface div_ctrl_if;

  logic clear; // Wipes the partial remainder, quotient and counter.
  logic load; // Takes the operands on request acceptance.
  logic step; // Performs one shift and trial subtraction.
  logic latch_q; // Keeps the trial difference and sets the quotient bit.
  logic rem_neg; // Sign of the current trial difference.
  logic count_done; // All DIV_WIDTH steps have been done.

  modport ctrl_mp (
    output clear, load, step, latch_q,
    input rem_neg, count_done
  );

  modport dp_mp (
    input clear, load, step, latch_q,
    output rem_neg, count_done
  );

endinterface

// ==== div_req_if.sv ====
// Both sides hold their data while their valid is high and the other side is not ready.
`timescale 1ns/1ns
`include "div_consts.svh"

interface div_req_if;

  logic src_valid;
  logic src_ready;
  logic [`DIV_WIDTH-1:0] dividend;
  logic [`DIV_WIDTH-1:0] divisor;

  logic dest_valid;
  logic dest_ready;
  logic [`DIV_WIDTH-1:0] quotient;
  logic [`DIV_WIDTH-1:0] remainder;

  modport regs_mp (
    output src_valid, dividend, divisor, dest_ready,
    input src_ready, dest_valid, quotient, remainder
  );

  modport core_mp (
    input src_valid, dividend, divisor, dest_ready,
    output src_ready, dest_valid, quotient, remainder
  );

endinterface

// ==== div_controller.sv ====
// Accepts one request at a time; the result appears DIV_WIDTH+1 cycles after acceptance.
`timescale 1ns/1ns

module div_controller import div_pkg::*; (
  input logic clk,
  input logic rst,
  div_req_if.core_mp req,
  div_ctrl_if.ctrl_mp ctl
);

  div_state_e state;
  div_state_e state_nxt;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    req.src_ready = 1'b0;
    req.dest_valid = 1'b0;
    ctl.load = 1'b0;
    ctl.step = 1'b0;
    ctl.latch_q = 1'b0;

    case (state)
      ST_IDLE: begin
        req.src_ready = 1'b1; // Only place where a request is taken.
        if (req.src_valid) begin
          ctl.load = 1'b1;
          state_nxt = ST_ITER;
        end
      end

      ST_ITER: begin
        if (!ctl.count_done) begin
          ctl.step = 1'b1;
          // A negative trial difference means restore, so the old remainder stays.
          ctl.latch_q = !ctl.rem_neg;
        end else begin
          req.dest_valid = 1'b1;
          if (req.dest_ready) begin
            state_nxt = ST_IDLE;
          end else begin
            state_nxt = ST_HOLD; // Consumer is busy, so keep offering.
          end
        end
      end

      ST_HOLD: begin
        req.dest_valid = 1'b1;
        if (req.dest_ready) begin
          state_nxt = ST_IDLE;
        end
      end

      default: begin
        state_nxt = ST_IDLE;
      end
    endcase

    // The datapath is wiped once the result has been handed over.
    ctl.clear = req.dest_valid && req.dest_ready;
  end

endmodule

// ==== div_datapath.sv ====
// Unsigned only; a zero divisor returns an all-ones quotient and the dividend as remainder.
`timescale 1ns/1ns
`include "div_consts.svh"

module div_datapath (
  input logic clk,
  input logic rst,
  div_req_if.core_mp req,
  div_ctrl_if.dp_mp ctl
);

  logic [`DIV_WIDTH:0] rem_q; // Partial remainder, one bit wider than operands.
  logic [`DIV_WIDTH-1:0] quo_q; // Dividend shifts out, quotient shifts in.
  logic [`DIV_WIDTH-1:0] dsr_q; // Divisor copy taken at load.
  logic [`DIV_CNT_WIDTH-1:0] cnt_q; // Steps still to do.
  logic [`DIV_WIDTH:0] rem_shift;
  logic [`DIV_WIDTH:0] rem_diff;

  // Shift the next dividend bit into the partial remainder.
  assign rem_shift = {rem_q[`DIV_WIDTH-1:0], quo_q[`DIV_WIDTH-1]};

  // The remainder stays below the divisor, so the MSB of the difference is its sign.
  assign rem_diff = rem_shift - {1'b0, dsr_q};

  assign ctl.rem_neg = rem_diff[`DIV_WIDTH];
  assign ctl.count_done = (cnt_q == '0);

  assign req.quotient = quo_q;
  assign req.remainder = rem_q[`DIV_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rem_q <= '0;
      quo_q <= '0;
      dsr_q <= '0;
      cnt_q <= '0;
    end else if (ctl.clear) begin
      rem_q <= '0;
      quo_q <= '0;
      cnt_q <= '0;
    end else if (ctl.load) begin
      rem_q <= '0;
      quo_q <= req.dividend;
      dsr_q <= req.divisor;
      cnt_q <= `DIV_CNT_WIDTH'(`DIV_WIDTH);
    end else if (ctl.step) begin
      if (ctl.latch_q) begin
        rem_q <= rem_diff; // Difference fits, keep it.
      end else begin
        rem_q <= rem_shift; // Restore the shifted remainder.
      end
      quo_q <= {quo_q[`DIV_WIDTH-2:0], ctl.latch_q};
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// ==== div_regs.sv ====
// Classic single cycles only, sel is ignored and upper data bits above DIV_WIDTH read as zero.
`timescale 1ns/1ns
`include "div_consts.svh"

module div_regs import div_pkg::*; (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic [`WB_ADDR_WIDTH-1:0] wb_adr,
  input logic [`WB_DATA_WIDTH-1:0] wb_dat_i,
  output logic [`WB_DATA_WIDTH-1:0] wb_dat_o,
  output logic wb_ack,
  output logic irq,
  div_req_if.regs_mp req
);

  div_reg_e reg_addr;
  logic bus_req;
  logic wr_en;
  logic rd_en;
  logic start_wr;
  logic quot_rd;
  logic accept;
  logic xfer;
  logic pending_q;
  logic busy_q;
  logic done_q;
  logic [`DIV_WIDTH-1:0] dividend_q;
  logic [`DIV_WIDTH-1:0] divisor_q;
  logic [`DIV_WIDTH-1:0] quot_q;
  logic [`DIV_WIDTH-1:0] rem_q;
  logic [`WB_DATA_WIDTH-1:0] rd_data;

  assign reg_addr = div_reg_e'(wb_adr);
  assign bus_req = wb_cyc && wb_stb && !wb_ack; // Blocks a second ack in a row.
  assign wr_en = bus_req && wb_we;
  assign rd_en = bus_req && !wb_we;
  assign start_wr = wr_en && (reg_addr == REG_CTRL) && wb_dat_i[0];
  assign quot_rd = rd_en && (reg_addr == REG_QUOT);
  assign accept = pending_q && req.src_ready;
  assign xfer = req.dest_valid && !done_q;

  assign req.src_valid = pending_q;
  assign req.dividend = dividend_q;
  assign req.divisor = divisor_q;
  assign req.dest_ready = !done_q; // An unread result holds off the next one.
  assign irq = done_q;

  always_comb begin
    rd_data = '0;
    case (reg_addr)
      REG_DIVIDEND: rd_data = {{(`WB_DATA_WIDTH-`DIV_WIDTH){1'b0}}, dividend_q};
      REG_DIVISOR: rd_data = {{(`WB_DATA_WIDTH-`DIV_WIDTH){1'b0}}, divisor_q};
      REG_STATUS: rd_data = {{(`WB_DATA_WIDTH-3){1'b0}}, pending_q, done_q, busy_q};
      REG_QUOT: rd_data = {{(`WB_DATA_WIDTH-`DIV_WIDTH){1'b0}}, quot_q};
      REG_REM: rd_data = {{(`WB_DATA_WIDTH-`DIV_WIDTH){1'b0}}, rem_q};
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wb_ack <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack <= bus_req;
      if (rd_en) begin
        wb_dat_o <= rd_data; // Stays valid through the ack cycle.
      end
    end
  end

  // Operands are frozen while a request is still waiting for acceptance.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      dividend_q <= '0;
      divisor_q <= '0;
    end else if (wr_en && !pending_q) begin
      if (reg_addr == REG_DIVIDEND) begin
        dividend_q <= wb_dat_i[`DIV_WIDTH-1:0];
      end
      if (reg_addr == REG_DIVISOR) begin
        divisor_q <= wb_dat_i[`DIV_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pending_q <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (accept) begin
        pending_q <= 1'b0;
      end else if (start_wr && !busy_q) begin
        pending_q <= 1'b1;
      end
      // Busy covers the core's work, from acceptance until it offers a result.
      if (accept) begin
        busy_q <= 1'b1;
      end else if (req.dest_valid) begin
        busy_q <= 1'b0;
      end
      if (xfer) begin
        done_q <= 1'b1;
      end else if (quot_rd) begin
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      quot_q <= '0;
      rem_q <= '0;
    end else if (xfer) begin
      quot_q <= req.quotient;
      rem_q <= req.remainder;
    end
  end

endmodule

// ==== div_top.sv ====
// One division in flight plus one held result; irq stays high until the quotient is read.
`timescale 1ns/1ns
`include "div_consts.svh"

module div_top (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic [`WB_ADDR_WIDTH-1:0] wb_adr,
  input logic [`WB_DATA_WIDTH-1:0] wb_dat_i,
  output logic [`WB_DATA_WIDTH-1:0] wb_dat_o,
  output logic wb_ack,
  output logic irq
);

  div_req_if req_if (); // Register block to core.
  div_ctrl_if ctrl_if (); // Controller to datapath.

  div_regs u_regs (
    .clk (clk),
    .rst (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we (wb_we),
    .wb_adr (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack (wb_ack),
    .irq (irq),
    .req (req_if.regs_mp)
  );

  div_controller u_ctrl (
    .clk (clk),
    .rst (rst),
    .req (req_if.core_mp),
    .ctl (ctrl_if.ctrl_mp)
  );

  div_datapath u_dp (
    .clk (clk),
    .rst (rst),
    .req (req_if.core_mp),
    .ctl (ctrl_if.dp_mp)
  );

endmodule

// ==== div_assertions.sv ====
// Wishbone handshake and interrupt checks, bound into div_top and sampled on the rising clock.
`timescale 1ns/1ns

module div_assertions (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic irq
);

  // An ack answers a request that was seen on the previous edge.
  ack_after_req: assert property (@(posedge clk) disable iff (!rst)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack rose without a request on the cycle before");

  ack_single: assert property (@(posedge clk) disable iff (!rst)
    wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for two cycles");

  irq_in_reset: assert property (@(posedge clk) !rst |-> !irq)
    else $error("irq high while reset is asserted");

endmodule

bind div_top div_assertions i_assertions (
  .clk (clk),
  .rst (rst),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .irq (irq)
);

// ==== tb_div_top.sv ====
// Reads div_trace.txt from the project root; the bus tasks run one Wishbone cycle at a time.
`timescale 1ns/1ns
`include "div_consts.svh"

module tb_div_top import div_pkg::*; ();

  localparam int BUS_TIMEOUT = 20; // Cycles allowed for one ack.
  localparam int POLL_LIMIT = 100; // Status reads allowed while polling.

  logic clk;
  logic rst;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [`WB_ADDR_WIDTH-1:0] wb_adr;
  logic [`WB_DATA_WIDTH-1:0] wb_dat_i;
  logic [`WB_DATA_WIDTH-1:0] wb_dat_o;
  logic wb_ack;
  logic irq;
  int err_count;
  int check_count;
  int test_count;
  int test_err_base;

  div_top i_dut (
    .clk (clk),
    .rst (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we (wb_we),
    .wb_adr (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack (wb_ack),
    .irq (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic check(input string name, input logic [`WB_DATA_WIDTH-1:0] actual,
                       input logic [`WB_DATA_WIDTH-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic bus_access(input logic we, input logic [`WB_ADDR_WIDTH-1:0] addr,
                            input logic [`WB_DATA_WIDTH-1:0] wdata,
                            output logic [`WB_DATA_WIDTH-1:0] rdata);
    int cycles;
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = addr;
    wb_dat_i = wdata;
    cycles = 0;
    do begin
      @(posedge clk);
      #1; // Ack and read data are registered, so they are stable here.
      cycles++;
    end while (!wb_ack && cycles < BUS_TIMEOUT);
    if (!wb_ack) begin
      abort_run("Timeout: the DUT never acknowledged a bus cycle.");
    end
    rdata = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(input logic [`WB_ADDR_WIDTH-1:0] addr,
                          input logic [`WB_DATA_WIDTH-1:0] data);
    logic [`WB_DATA_WIDTH-1:0] ignored;
    bus_access(1'b1, addr, data, ignored);
  endtask

  task automatic wb_read(input logic [`WB_ADDR_WIDTH-1:0] addr,
                         output logic [`WB_DATA_WIDTH-1:0] data);
    bus_access(1'b0, addr, '0, data);
  endtask

  // Reads REG_STATUS until the masked bits equal want.
  task automatic poll_status(input logic [`WB_DATA_WIDTH-1:0] mask,
                             input logic [`WB_DATA_WIDTH-1:0] want);
    logic [`WB_DATA_WIDTH-1:0] status;
    int polls;
    polls = 0;
    do begin
      wb_read(REG_STATUS, status);
      polls++;
    end while ((status & mask) !== want && polls < POLL_LIMIT);
    if ((status & mask) !== want) begin
      abort_run("Timeout: the status register never reached the awaited state.");
    end
  endtask

  task automatic run_division(input logic [`WB_DATA_WIDTH-1:0] dividend,
                              input logic [`WB_DATA_WIDTH-1:0] divisor,
                              input logic [`WB_DATA_WIDTH-1:0] exp_q,
                              input logic [`WB_DATA_WIDTH-1:0] exp_r);
    logic [`WB_DATA_WIDTH-1:0] rd;
    wb_write(REG_DIVIDEND, dividend);
    wb_write(REG_DIVISOR, divisor);
    wb_write(REG_CTRL, 32'h1);
    poll_status(32'h2, 32'h2); // Done bit.
    check("irq", 32'(irq), 32'h1);
    wb_read(REG_QUOT, rd);
    check("quotient", rd, exp_q);
    wb_read(REG_REM, rd);
    check("remainder", rd, exp_r);
    wb_read(REG_STATUS, rd);
    check("status.done", rd & 32'h2, 32'h0);
    check("irq", 32'(irq), 32'h0);
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (err_count == test_err_base) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  initial begin
    int fd;
    int fields;
    int vectors;
    string line;
    logic [`WB_DATA_WIDTH-1:0] dvd;
    logic [`WB_DATA_WIDTH-1:0] dvs;
    logic [`WB_DATA_WIDTH-1:0] exp_q;
    logic [`WB_DATA_WIDTH-1:0] exp_r;
    logic [`WB_DATA_WIDTH-1:0] rd;
    err_count = 0;
    check_count = 0;
    test_count = 0;
    test_err_base = 0;
    vectors = 0;
    rst = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_i = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b1;

    wb_read(REG_STATUS, rd);
    check("status", rd, 32'h0);
    wb_read(REG_QUOT, rd);
    check("quotient", rd, 32'h0);
    wb_read(REG_REM, rd);
    check("remainder", rd, 32'h0);
    wb_read(3'd6, rd);
    check("wb_dat_o@6", rd, 32'h0);
    wb_read(3'd7, rd);
    check("wb_dat_o@7", rd, 32'h0);
    check("irq", 32'(irq), 32'h0);
    end_test("reset values");

    wb_write(REG_DIVIDEND, 32'hdead_beef);
    wb_read(REG_DIVIDEND, rd);
    check("dividend", rd, 32'h0000_beef); // Only DIV_WIDTH bits are kept.
    wb_write(REG_DIVISOR, 32'h1234_5678);
    wb_read(REG_DIVISOR, rd);
    check("divisor", rd, 32'h0000_5678);
    end_test("operand readback");

    fd = $fopen("div_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open div_trace.txt.");
    end else begin
      while (!$feof(fd)) begin
        line = ""; // An empty read at the end of the file leaves nothing to parse.
        fields = $fgets(line, fd);
        fields = $sscanf(line, "%h %h %h %h", dvd, dvs, exp_q, exp_r);
        if (fields == 4) begin // Comment and blank lines do not parse.
          vectors++;
          if (dvs != 0) begin
            check("trace q*d+r", exp_q * dvs + exp_r, dvd);
            check("trace r<d", 32'(exp_r < dvs), 32'h1);
          end else begin
            check("trace quotient", exp_q, 32'h0000_ffff);
            check("trace remainder", exp_r, dvd);
          end
          run_division(dvd, dvs, exp_q, exp_r);
        end
      end
      $fclose(fd);
    end
    if (vectors == 0) begin
      abort_run("No division vectors were found in div_trace.txt.");
    end
    end_test("trace divisions");

    run_division(32'h5a5a, 32'h0, 32'h0000_ffff, 32'h5a5a);
    end_test("divide by zero");

    // First result stays unread while the second division runs.
    wb_write(REG_DIVIDEND, 32'h00c8);
    wb_write(REG_DIVISOR, 32'h0007);
    wb_write(REG_CTRL, 32'h1);
    poll_status(32'h2, 32'h2);
    wb_write(REG_DIVIDEND, 32'h0100);
    wb_write(REG_DIVISOR, 32'h0003);
    wb_write(REG_CTRL, 32'h1);
    poll_status(32'h5, 32'h0); // Busy and pending both clear.
    wb_read(REG_STATUS, rd);
    check("status", rd, 32'h2);
    wb_read(REG_QUOT, rd);
    check("quotient", rd, 32'h001c);
    poll_status(32'h2, 32'h2);
    wb_read(REG_QUOT, rd);
    check("quotient", rd, 32'h0055);
    wb_read(REG_REM, rd);
    check("remainder", rd, 32'h0001);
    end_test("back-pressure");

    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== div_trace.txt ====
# Columns in hex: dividend divisor expected_quotient expected_remainder
# A zero divisor expects an all-ones quotient and the dividend as remainder.
0064 0007 000e 0002
ffff 0001 ffff 0000
ffff ffff 0001 0000
0000 0005 0000 0000
1234 0010 0123 0004
0005 0009 0000 0005
abcd 0000 ffff abcd
0000 0000 ffff 0000
8000 0003 2aaa 0002
fffe 00ff 0100 00fe
7fff 0100 007f 00ff
03e8 000a 0064 0000
c350 00c8 00fa 0000
1001 1000 0001 0001

// ==== div_top.f ====
+incdir+.
div_pkg.sv
div_ctrl_if.sv
div_req_if.sv
div_controller.sv
div_datapath.sv
div_regs.sv
div_top.sv
div_assertions.sv
tb_div_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f div_top.f --top-module tb_div_top
out="$(./obj_dir/Vtb_div_top 2>&1)" || true
echo "$out"
if echo "$out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1
